/* source/tsconf_pkg.sv */
package tsconf_pkg;

	//////////////////////////////
	// bus widths
	//////////////////////////////

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// page numbers
	localparam int PAGE_W  = 8;
	localparam int ROMPG_W = 5;

	typedef logic [PAGE_W-1:0]  page_t;
	typedef logic [ROMPG_W-1:0] rompg_t;

	//////////////////////////////
	// extended ports
	//////////////////////////////

	// low address byte shared by all extended ports
	localparam logic [7:0] XPORT_LOW = 8'hAF;

	// high address byte selects the register
	typedef enum logic [7:0] {
		XP_IM2VECT = 8'h0F,
		XP_PAGE0   = 8'h10,
		XP_PAGE1   = 8'h11,
		XP_PAGE2   = 8'h12,
		XP_PAGE3   = 8'h13,
		XP_MEMCONF = 8'h21,
		XP_INTMASK = 8'h2A
	} xport_e;

	// memconf bits
	localparam int MC_ROM_WE = 1;   // rom writable in window 0
	localparam int MC_W0_RAM = 3;   // ram instead of rom in window 0

	//////////////////////////////
	// frame interrupt
	//////////////////////////////

	// frame length in fclk cycles
	localparam int FRAME_CYCLES = 2048;
	localparam int FRAME_W      = $clog2(FRAME_CYCLES);

	// longest int_n low time
	localparam int INT_CYCLES = 32;
	localparam int INT_LEN_W  = $clog2(INT_CYCLES);

	typedef enum logic {
		INT_IDLE   = 1'b0,
		INT_ACTIVE = 1'b1
	} int_state_e;

	//////////////////////////////
	// reset values
	//////////////////////////////

	// rom in window 0, no rom writes
	localparam logic [DATA_W-1:0] MEMCONF_RST = 8'h00;

	// pentagon-like default map for windows 0..3
	localparam page_t PAGE_RST [0:3] = '{8'd0, 8'd5, 8'd2, 8'd0};

	localparam logic [DATA_W-1:0] IM2VECT_RST = 8'hFF;

	// interrupts enabled after reset
	localparam logic [DATA_W-1:0] INTMASK_RST = 8'h01;

endpackage

/* source/zsignals.sv */
`timescale 1ns/1ps

module zsignals (
	input  logic fclk,
	input  logic arst_n,

	// raw z80 strobes
	input  logic iorq_n,
	input  logic mreq_n,
	input  logic rd_n,
	input  logic wr_n,
	input  logic m1_n,

	// registered levels
	output logic iorq,
	output logic mreq,
	output logic rd,
	output logic wr,
	output logic m1,

	// cycle types
	output logic iord,
	output logic iowr,
	output logic memrd,
	output logic memwr,
	output logic intack,

	// first-cycle pulses
	output logic iowr_s,
	output logic intack_s
);

	logic iowr_r;
	logic intack_r;

	//////////////////////////////
	// strobe sampling
	//////////////////////////////

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			iorq <= 1'b0;
			mreq <= 1'b0;
			rd   <= 1'b0;
			wr   <= 1'b0;
			m1   <= 1'b0;
		end else begin
			iorq <= ~iorq_n;
			mreq <= ~mreq_n;
			rd   <= ~rd_n;
			wr   <= ~wr_n;
			m1   <= ~m1_n;
		end
	end

	// cycle types from sampled levels
	assign iord   = iorq & rd & ~m1;
	assign iowr   = iorq & wr;
	assign memrd  = mreq & rd;
	assign memwr  = mreq & wr;
	assign intack = iorq & m1;

	//////////////////////////////
	// start pulses
	//////////////////////////////

	// one pulse per z80 cycle, however many fclk it spans
	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			iowr_r   <= 1'b0;
			intack_r <= 1'b0;
		end else begin
			iowr_r   <= iowr;
			intack_r <= intack;
		end
	end

	assign iowr_s   = iowr & ~iowr_r;
	assign intack_s = intack & ~intack_r;

endmodule

/* source/zports.sv */
`timescale 1ns/1ps

module zports (
	input  logic                            fclk,
	input  logic                            arst_n,

	input  logic [tsconf_pkg::ADDR_W-1:0]   a,
	input  logic [tsconf_pkg::DATA_W-1:0]   din,
	input  logic                            iord,
	input  logic                            iowr_s,

	// readback
	output logic [tsconf_pkg::DATA_W-1:0]   dout,
	output logic                            dataout,

	// configuration
	output logic [tsconf_pkg::DATA_W-1:0]   memconf,
	output tsconf_pkg::page_t               xt_page0,
	output tsconf_pkg::page_t               xt_page1,
	output tsconf_pkg::page_t               xt_page2,
	output tsconf_pkg::page_t               xt_page3,
	output logic [tsconf_pkg::DATA_W-1:0]   im2vect,
	output logic                            intmask_en
);

	logic                          port_lo;
	logic                          port_known;
	logic [7:0]                    port_hi;
	logic [tsconf_pkg::DATA_W-1:0] intmask;
	logic [tsconf_pkg::DATA_W-1:0] rd_mux;

	assign port_hi = a[tsconf_pkg::ADDR_W-1 -: 8];
	assign port_lo = (a[7:0] == tsconf_pkg::XPORT_LOW);

	//////////////////////////////
	// readback
	//////////////////////////////

	always_comb begin
		port_known = 1'b1;
		rd_mux     = '0;
		case (port_hi)
			tsconf_pkg::XP_PAGE0:   rd_mux = xt_page0;
			tsconf_pkg::XP_PAGE1:   rd_mux = xt_page1;
			tsconf_pkg::XP_PAGE2:   rd_mux = xt_page2;
			tsconf_pkg::XP_PAGE3:   rd_mux = xt_page3;
			tsconf_pkg::XP_MEMCONF: rd_mux = memconf;
			tsconf_pkg::XP_IM2VECT: rd_mux = im2vect;
			tsconf_pkg::XP_INTMASK: rd_mux = intmask;
			default:                port_known = 1'b0;
		endcase
	end

	// unknown ports leave the bus alone
	assign dataout = iord & port_lo & port_known;
	assign dout    = rd_mux;

	//////////////////////////////
	// config registers
	//////////////////////////////

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			memconf  <= tsconf_pkg::MEMCONF_RST;
			xt_page0 <= tsconf_pkg::PAGE_RST[0];
			xt_page1 <= tsconf_pkg::PAGE_RST[1];
			xt_page2 <= tsconf_pkg::PAGE_RST[2];
			xt_page3 <= tsconf_pkg::PAGE_RST[3];
			im2vect  <= tsconf_pkg::IM2VECT_RST;
			intmask  <= tsconf_pkg::INTMASK_RST;
		end else if (iowr_s && port_lo) begin
			case (port_hi)
				tsconf_pkg::XP_PAGE0:   xt_page0 <= din;
				tsconf_pkg::XP_PAGE1:   xt_page1 <= din;
				tsconf_pkg::XP_PAGE2:   xt_page2 <= din;
				tsconf_pkg::XP_PAGE3:   xt_page3 <= din;
				tsconf_pkg::XP_MEMCONF: memconf  <= din;
				tsconf_pkg::XP_IM2VECT: im2vect  <= din;
				tsconf_pkg::XP_INTMASK: intmask  <= din;
				default: ;
			endcase
		end
	end

	// bit 0 enables the frame interrupt
	assign intmask_en = intmask[0];

endmodule

/* source/pager.sv */
`timescale 1ns/1ps

module pager (
	input  logic                            fclk,
	input  logic                            arst_n,

	input  logic [tsconf_pkg::ADDR_W-1:0]   a,
	input  logic                            memrd,
	input  logic                            memwr,

	input  logic [tsconf_pkg::DATA_W-1:0]   memconf,
	input  tsconf_pkg::page_t               xt_page0,
	input  tsconf_pkg::page_t               xt_page1,
	input  tsconf_pkg::page_t               xt_page2,
	input  tsconf_pkg::page_t               xt_page3,

	// rom chip
	output logic                            csrom,
	output logic                            romoe_n,
	output logic                            romwe_n,
	output tsconf_pkg::rompg_t              rompg,

	// ram side
	output logic                            ram_rd,
	output logic                            ram_wr,
	output tsconf_pkg::page_t               ram_page
);

	logic [1:0]        win;
	tsconf_pkg::page_t win_page;
	logic              rom_sel;
	logic              mem_cyc;

	// 16k window from the top address bits
	assign win = a[tsconf_pkg::ADDR_W-1 -: 2];

	always_comb begin
		case (win)
			2'd0:    win_page = xt_page0;
			2'd1:    win_page = xt_page1;
			2'd2:    win_page = xt_page2;
			default: win_page = xt_page3;
		endcase
	end

	assign rom_sel = (win == 2'd0) && !memconf[tsconf_pkg::MC_W0_RAM];
	assign mem_cyc = memrd | memwr;

	//////////////////////////////
	// chip controls
	//////////////////////////////

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			csrom   <= 1'b0;
			romoe_n <= 1'b1;
			romwe_n <= 1'b1;
			ram_rd  <= 1'b0;
			ram_wr  <= 1'b0;
		end else begin
			csrom   <= rom_sel & mem_cyc;
			romoe_n <= ~(rom_sel & memrd);
			// write protect unless memconf allows it
			romwe_n <= ~(rom_sel & memwr & memconf[tsconf_pkg::MC_ROM_WE]);
			ram_rd  <= ~rom_sel & memrd;
			ram_wr  <= ~rom_sel & memwr;
		end
	end

	// page numbers only move on a memory cycle
	always_ff @(posedge fclk) begin
		if (mem_cyc) begin
			if (rom_sel)
				rompg <= xt_page0[tsconf_pkg::ROMPG_W-1:0];
			else
				ram_page <= win_page;
		end
	end

endmodule

/* source/zint.sv */
`timescale 1ns/1ps

module zint (
	input  logic fclk,
	input  logic arst_n,
	input  logic intmask_en,
	input  logic intack_s,
	output logic int_n
);

	logic [tsconf_pkg::FRAME_W-1:0]   frame_cnt;
	logic [tsconf_pkg::INT_LEN_W-1:0] len_cnt;
	logic                             frame_wrap;
	logic                             len_done;
	tsconf_pkg::int_state_e           state;

	//////////////////////////////
	// frame timer
	//////////////////////////////

	assign frame_wrap = (frame_cnt == tsconf_pkg::FRAME_W'(tsconf_pkg::FRAME_CYCLES - 1));

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n)
			frame_cnt <= '0;
		else if (frame_wrap)
			frame_cnt <= '0;
		else
			frame_cnt <= frame_cnt + 1'b1;
	end

	//////////////////////////////
	// int fsm
	//////////////////////////////

	assign len_done = (len_cnt == tsconf_pkg::INT_LEN_W'(tsconf_pkg::INT_CYCLES - 1));

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= tsconf_pkg::INT_IDLE;
			len_cnt <= '0;
		end else begin
			case (state)
				tsconf_pkg::INT_IDLE: begin
					len_cnt <= '0;
					if (frame_wrap && intmask_en)
						state <= tsconf_pkg::INT_ACTIVE;
				end
				tsconf_pkg::INT_ACTIVE: begin
					len_cnt <= len_cnt + 1'b1;
					// ack or timeout, whichever first
					if (intack_s || len_done)
						state <= tsconf_pkg::INT_IDLE;
				end
				default: state <= tsconf_pkg::INT_IDLE;
			endcase
		end
	end

	assign int_n = (state != tsconf_pkg::INT_ACTIVE);

endmodule

/* source/tsconf_core.sv */
`timescale 1ns/1ps

module tsconf_core (
	input  logic                            fclk,
	input  logic                            arst_n,

	// z80 bus
	input  logic                            iorq_n,
	input  logic                            mreq_n,
	input  logic                            rd_n,
	input  logic                            wr_n,
	input  logic                            m1_n,
	input  logic [tsconf_pkg::ADDR_W-1:0]   a,
	inout  wire  [tsconf_pkg::DATA_W-1:0]   d,
	output logic                            int_n,

	// rom chip
	output logic                            csrom,
	output logic                            romoe_n,
	output logic                            romwe_n,
	output tsconf_pkg::rompg_t              rompg,

	// ram side
	output tsconf_pkg::page_t               ram_page,
	output logic                            ram_rd,
	output logic                            ram_wr
);

	logic iord;
	logic memrd;
	logic memwr;
	logic intack;
	logic iowr_s;
	logic intack_s;

	logic [tsconf_pkg::DATA_W-1:0] dout;
	logic                          dataout;
	logic [tsconf_pkg::DATA_W-1:0] memconf;
	logic [tsconf_pkg::DATA_W-1:0] im2vect;
	logic                          intmask_en;
	tsconf_pkg::page_t             xt_page0;
	tsconf_pkg::page_t             xt_page1;
	tsconf_pkg::page_t             xt_page2;
	tsconf_pkg::page_t             xt_page3;

	//////////////////////////////
	// data bus
	//////////////////////////////

	// port readback wins over the im2 vector
	assign d = dataout ? dout : (intack ? im2vect : {tsconf_pkg::DATA_W{1'bz}});

	zsignals zsignals (
		.fclk     (fclk),
		.arst_n   (arst_n),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.iorq     (),
		.mreq     (),
		.rd       (),
		.wr       (),
		.m1       (),
		.iord     (iord),
		.iowr     (),
		.memrd    (memrd),
		.memwr    (memwr),
		.intack   (intack),
		.iowr_s   (iowr_s),
		.intack_s (intack_s)
	);

	zports zports (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.a          (a),
		.din        (d),
		.iord       (iord),
		.iowr_s     (iowr_s),
		.dout       (dout),
		.dataout    (dataout),
		.memconf    (memconf),
		.xt_page0   (xt_page0),
		.xt_page1   (xt_page1),
		.xt_page2   (xt_page2),
		.xt_page3   (xt_page3),
		.im2vect    (im2vect),
		.intmask_en (intmask_en)
	);

	pager pager (
		.fclk     (fclk),
		.arst_n   (arst_n),
		.a        (a),
		.memrd    (memrd),
		.memwr    (memwr),
		.memconf  (memconf),
		.xt_page0 (xt_page0),
		.xt_page1 (xt_page1),
		.xt_page2 (xt_page2),
		.xt_page3 (xt_page3),
		.csrom    (csrom),
		.romoe_n  (romoe_n),
		.romwe_n  (romwe_n),
		.rompg    (rompg),
		.ram_rd   (ram_rd),
		.ram_wr   (ram_wr),
		.ram_page (ram_page)
	);

	zint zint (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.intmask_en (intmask_en),
		.intack_s   (intack_s),
		.int_n      (int_n)
	);

endmodule

/* tests/tsconf_props.sv */
`timescale 1ns/1ps

module tsconf_props (
	input logic fclk,
	input logic arst_n,
	input logic int_n,
	input logic csrom,
	input logic romoe_n,
	input logic romwe_n,
	input logic ram_rd
);

	int low_cnt;
	int reset_errs = 0;
	int rom_errs   = 0;
	int cs_errs    = 0;
	int len_errs   = 0;
	int err_total;

	assign err_total = reset_errs + rom_errs + cs_errs + len_errs;

	// consecutive cycles with int_n low
	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n)
			low_cnt <= 0;
		else if (!int_n)
			low_cnt <= low_cnt + 1;
		else
			low_cnt <= 0;
	end

	//////////////////////////////
	// assertions
	//////////////////////////////

	a_int_rst: assert property (@(posedge fclk) !arst_n |-> int_n)
		else begin
			reset_errs++;
			$error("int_n low during reset");
		end

	a_rom_rw: assert property (@(posedge fclk) disable iff (!arst_n) romoe_n || romwe_n)
		else begin
			rom_errs++;
			$error("romoe_n and romwe_n both low");
		end

	a_chip_sel: assert property (@(posedge fclk) disable iff (!arst_n) !(csrom && ram_rd))
		else begin
			cs_errs++;
			$error("csrom and ram_rd both high");
		end

	// 32 low cycles max before release
	a_int_len: assert property (@(posedge fclk) disable iff (!arst_n)
		int_n || (low_cnt < tsconf_pkg::INT_CYCLES))
		else begin
			len_errs++;
			$error("int_n low longer than INT_CYCLES");
		end

endmodule

bind zint tsconf_props int_props (
	.fclk    (fclk),
	.arst_n  (arst_n),
	.int_n   (int_n),
	.csrom   (1'b0),
	.romoe_n (1'b1),
	.romwe_n (1'b1),
	.ram_rd  (1'b0)
);

bind pager tsconf_props mem_props (
	.fclk    (fclk),
	.arst_n  (arst_n),
	.int_n   (1'b1),
	.csrom   (csrom),
	.romoe_n (romoe_n),
	.romwe_n (romwe_n),
	.ram_rd  (ram_rd)
);

/* tests/tb_tsconf.sv */
`timescale 1ns/1ps

module tb_tsconf;

	localparam int CLK_HALF   = 20;
	localparam int RST_CYCLES = 3;
	localparam int MAX_CYCLES = 20000;
	localparam int NPORTS     = 7;

	logic                      fclk;
	logic                      arst_n;
	logic                      iorq_n;
	logic                      mreq_n;
	logic                      rd_n;
	logic                      wr_n;
	logic                      m1_n;
	logic [15:0]               a;
	wire  [7:0]                d;
	logic [7:0]                d_drv;
	logic                      d_en;
	logic                      int_n;
	logic                      csrom;
	logic                      romoe_n;
	logic                      romwe_n;
	tsconf_pkg::rompg_t        rompg;
	tsconf_pkg::page_t         ram_page;
	logic                      ram_rd;
	logic                      ram_wr;

	int cycle_cnt  = 0;
	int value_errs = 0;
	int other_errs = 0;
	int props_errs = 0;
	int seed       = 49012;
	int rel_cycle;

	// ports in the order page0..3, memconf, im2vect, intmask
	tsconf_pkg::xport_e port_id [NPORTS] = '{tsconf_pkg::XP_PAGE0, tsconf_pkg::XP_PAGE1,
		tsconf_pkg::XP_PAGE2, tsconf_pkg::XP_PAGE3, tsconf_pkg::XP_MEMCONF,
		tsconf_pkg::XP_IM2VECT, tsconf_pkg::XP_INTMASK};
	logic [7:0] port_exp [NPORTS] = '{8'h00, 8'h05, 8'h02, 8'h00, 8'h00, 8'hFF, 8'h01};

	// outputs captured mid-cycle
	logic [7:0]         snap_d;
	logic               snap_drv;
	logic               snap_csrom;
	logic               snap_romoe_n;
	logic               snap_romwe_n;
	logic               snap_ram_rd;
	logic               snap_ram_wr;
	logic               snap_int_n;
	tsconf_pkg::rompg_t snap_rompg;
	tsconf_pkg::page_t  snap_ram_page;

	assign d = d_en ? d_drv : 8'hzz;

	tsconf_core UUT (
		.fclk     (fclk),
		.arst_n   (arst_n),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.a        (a),
		.d        (d),
		.int_n    (int_n),
		.csrom    (csrom),
		.romoe_n  (romoe_n),
		.romwe_n  (romwe_n),
		.rompg    (rompg),
		.ram_page (ram_page),
		.ram_rd   (ram_rd),
		.ram_wr   (ram_wr)
	);

	initial begin
		fclk = 1'b0;
		forever #CLK_HALF fclk = ~fclk;
	end

	always @(posedge fclk)
		cycle_cnt <= cycle_cnt + 1;

	initial begin
		while (cycle_cnt < MAX_CYCLES)
			@(posedge fclk);
		$display("timeout: run stopped after %0d cycles", cycle_cnt);
		$display("Finished with errors");
		$finish;
	end

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_page(input string name, input tsconf_pkg::page_t got,
		input tsconf_pkg::page_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_rompg(input string name, input tsconf_pkg::rompg_t got,
		input tsconf_pkg::rompg_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	//////////////////////////////
	// bus cycles
	//////////////////////////////

	task automatic take_snapshot();
		snap_d        = d;
		snap_drv      = UUT.dataout;
		snap_csrom    = csrom;
		snap_romoe_n  = romoe_n;
		snap_romwe_n  = romwe_n;
		snap_ram_rd   = ram_rd;
		snap_ram_wr   = ram_wr;
		snap_int_n    = int_n;
		snap_rompg    = rompg;
		snap_ram_page = ram_page;
	endtask

	// strobes held 3 cycles, outputs sampled two edges in
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic io, input logic write, input logic m1);
		@(posedge fclk);
		a      <= addr;
		d_drv  <= data;
		d_en   <= write;
		iorq_n <= ~io;
		mreq_n <= io;
		rd_n   <= write | m1;
		wr_n   <= ~write;
		m1_n   <= ~m1;
		repeat (2) @(posedge fclk);
		@(negedge fclk);
		take_snapshot();
		@(posedge fclk);
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
		d_en   <= 1'b0;
		repeat (2) @(posedge fclk);
	endtask

	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		bus_cycle({port, tsconf_pkg::XPORT_LOW}, data, 1'b1, 1'b1, 1'b0);
	endtask

	task automatic io_read(input logic [7:0] port);
		bus_cycle({port, tsconf_pkg::XPORT_LOW}, 8'h00, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic mem_read(input logic [15:0] addr);
		bus_cycle(addr, 8'h00, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		bus_cycle(addr, data, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic int_ack();
		bus_cycle(16'h0000, 8'h00, 1'b1, 1'b0, 1'b1);
	endtask

	task automatic set_port(input int idx, input logic [7:0] data);
		io_write(port_id[idx], data);
		port_exp[idx] = data;
	endtask

	task automatic check_all_ports();
		for (int i = 0; i < NPORTS; i++) begin
			io_read(port_id[i]);
			check_bit($sformatf("dataout@%02hAF", port_id[i]), snap_drv, 1'b1);
			check_byte($sformatf("d@%02hAF", port_id[i]), snap_d, port_exp[i]);
		end
	endtask

	task automatic wait_int_low(output int at_cycle);
		@(negedge fclk);
		while (int_n !== 1'b0)
			@(negedge fclk);
		at_cycle = cycle_cnt;
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic test_reset_defaults();
		check_bit("int_n", int_n, 1'b1);
		check_bit("csrom", csrom, 1'b0);
		check_bit("romoe_n", romoe_n, 1'b1);
		check_bit("romwe_n", romwe_n, 1'b1);
		check_bit("ram_rd", ram_rd, 1'b0);
		check_bit("ram_wr", ram_wr, 1'b0);
		check_bit("dataout", UUT.dataout, 1'b0);
		check_all_ports();
	endtask

	task automatic test_port_rw();
		for (int i = 0; i < NPORTS; i++)
			set_port(i, 8'($random(seed)));
		check_all_ports();
		// unlisted port 55AF
		io_write(8'h55, 8'($random(seed)));
		check_all_ports();
		io_read(8'h55);
		check_bit("dataout@55AF", snap_drv, 1'b0);
		check_byte("d@55AF", snap_d, 8'hzz);
		// back to rom in window 0 and interrupts on
		set_port(4, 8'h00);
		set_port(6, 8'h01);
	endtask

	task automatic test_window_paging();
		for (int w = 1; w < 4; w++) begin
			mem_read({w[1:0], 14'($random(seed))});
			check_page($sformatf("ram_page w%0d", w), snap_ram_page, port_exp[w]);
			check_bit("ram_rd", snap_ram_rd, 1'b1);
			check_bit("csrom", snap_csrom, 1'b0);
		end
		mem_read({2'b00, 14'($random(seed))});
		check_bit("csrom", snap_csrom, 1'b1);
		check_bit("romoe_n", snap_romoe_n, 1'b0);
		check_bit("ram_rd", snap_ram_rd, 1'b0);
		check_rompg("rompg", snap_rompg, port_exp[0][4:0]);
	endtask

	task automatic test_rom_protect();
		mem_write({2'b00, 14'($random(seed))}, 8'($random(seed)));
		check_bit("csrom", snap_csrom, 1'b1);
		check_bit("romwe_n", snap_romwe_n, 1'b1);
		check_bit("ram_wr", snap_ram_wr, 1'b0);
		set_port(4, 8'(1 << tsconf_pkg::MC_ROM_WE));
		mem_write({2'b00, 14'($random(seed))}, 8'($random(seed)));
		check_bit("romwe_n", snap_romwe_n, 1'b0);
		set_port(4, 8'(1 << tsconf_pkg::MC_W0_RAM));
		mem_read({2'b00, 14'($random(seed))});
		check_bit("csrom", snap_csrom, 1'b0);
		check_bit("ram_rd", snap_ram_rd, 1'b1);
		check_page("ram_page w0", snap_ram_page, port_exp[0]);
		// overlay write goes to ram as well
		mem_write({2'b00, 14'($random(seed))}, 8'($random(seed)));
		check_bit("csrom", snap_csrom, 1'b0);
		check_bit("romwe_n", snap_romwe_n, 1'b1);
		check_bit("ram_wr", snap_ram_wr, 1'b1);
		set_port(4, 8'h00);
	endtask

	task automatic test_frame_int();
		int fall_cycle;
		int next_fall;
		int low_cycles;
		wait_int_low(fall_cycle);
		if (fall_cycle != rel_cycle + tsconf_pkg::FRAME_CYCLES) begin
			other_errs++;
			$display("int_n fell at cycle %0d instead of cycle %0d", fall_cycle,
				rel_cycle + tsconf_pkg::FRAME_CYCLES);
		end
		int_ack();
		check_byte("d", snap_d, port_exp[5]);
		check_bit("int_n", snap_int_n, 1'b1);
		// second frame left unacknowledged
		wait_int_low(next_fall);
		if (next_fall - fall_cycle != tsconf_pkg::FRAME_CYCLES) begin
			other_errs++;
			$display("interrupt period was %0d cycles", next_fall - fall_cycle);
		end
		low_cycles = 0;
		while (int_n == 1'b0 && low_cycles < tsconf_pkg::INT_CYCLES) begin
			@(negedge fclk);
			low_cycles++;
		end
		if (int_n !== 1'b1) begin
			other_errs++;
			$display("int_n stayed low past %0d cycles without acknowledge",
				tsconf_pkg::INT_CYCLES);
		end
	endtask

	task automatic test_int_mask();
		logic stayed_high;
		set_port(6, 8'h00);
		stayed_high = 1'b1;
		repeat (tsconf_pkg::FRAME_CYCLES + tsconf_pkg::INT_CYCLES) begin
			@(negedge fclk);
			if (int_n !== 1'b1)
				stayed_high = 1'b0;
		end
		if (!stayed_high) begin
			other_errs++;
			$display("int_n fell although the frame interrupt was masked");
		end
	endtask

	initial begin
		arst_n <= 1'b0;
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
		a      <= 16'h0000;
		d_drv  <= 8'h00;
		d_en   <= 1'b0;
		repeat (RST_CYCLES) @(posedge fclk);
		arst_n <= 1'b1;
		@(negedge fclk);
		rel_cycle = cycle_cnt;

		test_reset_defaults();
		test_port_rw();
		test_window_paging();
		test_rom_protect();
		test_frame_int();
		test_int_mask();

		props_errs = UUT.zint.int_props.err_total + UUT.pager.mem_props.err_total;
		$display("errors: %0d value, %0d other, %0d assertion", value_errs, other_errs,
			props_errs);
		if (value_errs + other_errs + props_errs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* project.f */
source/tsconf_pkg.sv
source/zsignals.sv
source/zports.sv
source/pager.sv
source/zint.sv
source/tsconf_core.sv
tests/tsconf_props.sv
tests/tb_tsconf.sv

/* Makefile */
# Verilator build for the tsconf bus core testbench

VERILATOR  ?= verilator
TOP        ?= tb_tsconf
DUT_TOP    ?= tsconf_core
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the exact pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
